//--- compile.f
rv_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_core -f compile.f -o sim_rv_core
output=$(./obj_dir/sim_rv_core)
echo "$output"
if echo "$output" | grep -q "^Simulation completed successfully$"; then
	exit 0
fi
exit 1

//--- tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;

	logic  clock;
	logic  reset;
	word_t instr_addr;
	word_t instr_data;
	word_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	logic  data_read;
	logic  data_write;
	logic  data_ready;

	word_t rom [0:63];
	word_t dmem [0:255];
	word_t exp_addr [$];
	word_t exp_data [$];
	int    store_idx;
	int    errors;
	logic  random_ready;

	rv_core u_rv_core (.*);

	// asynchronous ROM and read port of the data memory
	assign instr_data = rom[instr_addr[7:2]];
	assign data_rdata = dmem[data_addr[9:2]];

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic word_t fill_word(input word_t addr);
		return 32'hc0de_0000 ^ addr;
	endfunction

	function automatic word_t imm_instr(input logic [6:0] opc, input reg_addr_t rd,
		input reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b010 & {3{opc == op_load}}, rd, opc};
	endfunction

	function automatic word_t reg_instr(input logic [6:0] funct7, input logic [2:0] funct3,
		input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic word_t store_instr(input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t branch_instr(input reg_addr_t rs1, input reg_addr_t rs2,
		input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t jal_instr(input reg_addr_t rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic expect_store(input word_t addr, input word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// program and the stores it must make in order
	task automatic load_program();
		for (int i = 0; i < 64; i++) begin
			rom[i] = BUBBLE_INSTR;
		end
		rom[0] = imm_instr(op_imm, 5'd1, 5'd0, 12'd5);
		rom[1] = store_instr(5'd1, 5'd0, 12'h100);
		rom[2] = imm_instr(op_imm, 5'd2, 5'd1, 12'h0f0);
		rom[3] = store_instr(5'd2, 5'd0, 12'h104);
		rom[4] = reg_instr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
		rom[5] = store_instr(5'd3, 5'd0, 12'h108);
		rom[6] = reg_instr(7'h20, 3'b000, 5'd4, 5'd1, 5'd3);
		rom[7] = store_instr(5'd4, 5'd0, 12'h10c);
		rom[8] = reg_instr(7'h00, 3'b111, 5'd5, 5'd4, 5'd2);
		rom[9] = store_instr(5'd5, 5'd0, 12'h110);
		rom[10] = reg_instr(7'h00, 3'b110, 5'd6, 5'd5, 5'd3);
		rom[11] = store_instr(5'd6, 5'd0, 12'h114);
		rom[12] = reg_instr(7'h00, 3'b100, 5'd7, 5'd6, 5'd4);
		rom[13] = store_instr(5'd7, 5'd0, 12'h118);
		rom[14] = reg_instr(7'h00, 3'b010, 5'd8, 5'd7, 5'd1);
		rom[15] = store_instr(5'd8, 5'd0, 12'h11c);
		// load, then an immediate consumer
		rom[16] = imm_instr(op_load, 5'd9, 5'd0, 12'h040);
		rom[17] = reg_instr(7'h00, 3'b000, 5'd10, 5'd9, 5'd1);
		rom[18] = store_instr(5'd10, 5'd0, 12'h120);
		// 5 != 0xf5 so it falls through
		rom[19] = branch_instr(5'd1, 5'd2, 13'd16);
		rom[20] = store_instr(5'd1, 5'd0, 12'h124);
		rom[21] = store_instr(5'd2, 5'd0, 12'h128);
		rom[22] = store_instr(5'd3, 5'd0, 12'h12c);
		// 1 == 1 so three stores are skipped
		rom[23] = branch_instr(5'd5, 5'd8, 13'd16);
		rom[24] = store_instr(5'd1, 5'd0, 12'h1f0);
		rom[25] = store_instr(5'd1, 5'd0, 12'h1f4);
		rom[26] = store_instr(5'd1, 5'd0, 12'h1f8);
		rom[27] = store_instr(5'd6, 5'd0, 12'h130);
		rom[28] = jal_instr(5'd11, 21'd8);
		rom[29] = store_instr(5'd1, 5'd0, 12'h1fc);
		rom[30] = store_instr(5'd11, 5'd0, 12'h134);
		// park here
		rom[31] = branch_instr(5'd0, 5'd0, 13'd0);

		exp_addr.delete();
		exp_data.delete();
		expect_store(32'h100, 32'h0000_0005);
		expect_store(32'h104, 32'h0000_00f5);
		expect_store(32'h108, 32'h0000_00fa);
		expect_store(32'h10c, 32'hffff_ff0b);
		expect_store(32'h110, 32'h0000_0001);
		expect_store(32'h114, 32'h0000_00fb);
		expect_store(32'h118, 32'hffff_fff0);
		expect_store(32'h11c, 32'h0000_0001);
		expect_store(32'h120, fill_word(32'h40) + 32'd5);
		expect_store(32'h124, 32'h0000_0005);
		expect_store(32'h128, 32'h0000_00f5);
		expect_store(32'h12c, 32'h0000_00fa);
		expect_store(32'h130, 32'h0000_00fb);
		// link of jal at 0x70
		expect_store(32'h134, 32'h0000_0074);
	endtask

	task automatic apply_reset();
		reset <= 1'b0;
		repeat (4) @(posedge clock);
		store_idx = 0;
		reset <= 1'b1;
	endtask

	task automatic wait_for_stores();
		int cycles;
		cycles = 0;
		while (store_idx < exp_addr.size() && cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		if (store_idx < exp_addr.size()) begin
			errors++;
			$display("timed out after %0d cycles with %0d of %0d stores seen",
				cycles, store_idx, exp_addr.size());
		end
		// stray stores from the parked loop would show up here
		cycles = 0;
		while (cycles < 40) begin
			@(posedge clock);
			cycles++;
		end
	endtask

	// store monitor and memory write
	always @(posedge clock) begin
		if (reset && data_write && data_ready) begin
			dmem[data_addr[9:2]] <= data_wdata;
			assert (store_idx < exp_addr.size()) else begin
				errors++;
				$display("** Error @%0t: unexpected store of %h to %h",
					$time, data_wdata, data_addr);
			end
			if (store_idx < exp_addr.size()) begin
				assert (data_addr == exp_addr[store_idx] && data_wdata == exp_data[store_idx])
				else begin
					errors++;
					$display("** Error @%0t: store %0d wrote %h to %h, expected %h to %h",
						$time, store_idx, data_wdata, data_addr,
						exp_data[store_idx], exp_addr[store_idx]);
				end
				store_idx++;
			end
		end
	end

	// ready driver, seeded in the process that draws the numbers
	initial begin
		data_ready = 1'b1;
		void'($urandom(32'h50e8_bf20));
		forever begin
			@(posedge clock);
			data_ready <= random_ready ? ($urandom % 3 != 0) : 1'b1;
		end
	end

	initial begin
		reset = 1'b0;
		random_ready = 1'b0;
		errors = 0;
		store_idx = 0;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fill_word(32'(i) << 2);
		end
		load_program();

		apply_reset();
		wait_for_stores();

		// random back-pressure on the data port
		random_ready <= 1'b1;
		apply_reset();
		wait_for_stores();

		$display("errors: %0d, stores seen: %0d", errors, store_idx);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core_props.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_props import rv_pkg::*; (
	input logic  clock,
	input logic  reset,
	input word_t instr_addr,
	input word_t data_addr,
	input word_t data_wdata,
	input logic  data_read,
	input logic  data_write,
	input logic  data_ready
);

	// first cycle out of reset
	reset_state: assert property (@(posedge clock)
		$rose(reset) |-> instr_addr == RESET_PC && !data_read && !data_write)
	else $error("core not in its reset state when reset released");

	// a held-off request must not move
	request_held: assert property (@(posedge clock) disable iff (!reset)
		(data_read || data_write) && !data_ready |=>
			$stable(data_addr) && $stable(data_wdata)
			&& $stable(data_read) && $stable(data_write))
	else $error("data request changed while waiting for ready");

	read_write_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(data_read && data_write))
	else $error("data read and write requested together");

endmodule

bind rv_core rv_core_props u_props (.*);

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	output word_t instr_addr,
	input  word_t instr_data,
	output word_t data_addr,
	output word_t data_wdata,
	input  word_t data_rdata,
	output logic  data_read,
	output logic  data_write,
	input  logic  data_ready
);

	logic      stall_front, stall_all;
	logic      flush_ifid, flush_idex, flush_exmem;
	logic      jump_taken, branch_taken;
	word_t     jump_target, branch_target;
	word_t     ifid_pc, ifid_instr;
	reg_addr_t rs1_addr, rs2_addr;
	word_t     rs1_data, rs2_data;
	word_t     idex_pc, idex_rs1_data, idex_rs2_data, idex_imm;
	reg_addr_t idex_rs1, idex_rs2, idex_rd;
	alu_op_t   idex_alu_op;
	logic      idex_use_imm, idex_link, idex_branch;
	logic      idex_mem_read, idex_mem_write, idex_reg_write;
	word_t     exmem_result, exmem_store_data, exmem_branch_target;
	reg_addr_t exmem_rd;
	logic      exmem_zero, exmem_branch;
	logic      exmem_mem_read, exmem_mem_write, exmem_reg_write;
	logic      wb_enable;
	reg_addr_t wb_addr;
	word_t     wb_data;

	fetch_stage u_fetch (.stall(stall_front), .flush(flush_ifid), .*);

	// load-use holds IF/ID only; ID/EX takes the bubble
	decode_stage u_decode (.stall(stall_all), .flush(flush_idex), .*);

	register_file u_regs (
		.clock        (clock),
		.reset        (reset),
		.read_addr_a  (rs1_addr),
		.read_addr_b  (rs2_addr),
		.read_data_a  (rs1_data),
		.read_data_b  (rs2_data),
		.write_enable (wb_enable),
		.write_addr   (wb_addr),
		.write_data   (wb_data)
	);

	execute_stage u_execute (.stall(stall_all), .flush(flush_exmem), .*);

	memory_stage u_memory (.stall(stall_all), .*);

	hazard_unit u_hazard (.*);

endmodule

`default_nettype wire

//--- hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import rv_pkg::*; (
	input  logic      idex_mem_read,
	input  reg_addr_t idex_rd,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  logic      jump_taken,
	input  logic      branch_taken,
	input  logic      data_read,
	input  logic      data_write,
	input  logic      data_ready,
	output logic      stall_front,
	output logic      stall_all,
	output logic      flush_ifid,
	output logic      flush_idex,
	output logic      flush_exmem
);

	logic load_use;
	logic mem_wait;

	// rs2 is compared even for I-type, costing a spare bubble at worst
	assign load_use = idex_mem_read && idex_rd != '0
		&& (idex_rd == rs1_addr || idex_rd == rs2_addr) && !branch_taken;

	assign mem_wait = (data_read || data_write) && !data_ready;

	assign stall_all = mem_wait;
	assign stall_front = mem_wait || load_use;

	// a stalled jal redirects once it leaves the load-use hold
	assign flush_ifid = !mem_wait && (branch_taken || (jump_taken && !load_use));
	assign flush_idex = !mem_wait && (branch_taken || load_use);
	assign flush_exmem = !mem_wait && branch_taken;

endmodule

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage import rv_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      stall,
	input  word_t     exmem_result,
	input  word_t     exmem_store_data,
	input  word_t     exmem_branch_target,
	input  reg_addr_t exmem_rd,
	input  logic      exmem_zero,
	input  logic      exmem_branch,
	input  logic      exmem_mem_read,
	input  logic      exmem_mem_write,
	input  logic      exmem_reg_write,
	output word_t     data_addr,
	output word_t     data_wdata,
	input  word_t     data_rdata,
	output logic      data_read,
	output logic      data_write,
	output logic      branch_taken,
	output word_t     branch_target,
	output logic      wb_enable,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	// request comes straight from EX/MEM, which holds while waiting
	assign data_addr = exmem_result;
	assign data_wdata = exmem_store_data;
	assign data_read = exmem_mem_read;
	assign data_write = exmem_mem_write;

	assign branch_taken = exmem_branch && exmem_zero;
	assign branch_target = exmem_branch_target;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_enable <= 1'b0;
		end else if (!stall) begin
			wb_enable <= exmem_reg_write;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			wb_addr <= exmem_rd;
			wb_data <= exmem_mem_read ? data_rdata : exmem_result;
		end
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import rv_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      stall,
	input  logic      flush,
	input  word_t     idex_pc,
	input  word_t     idex_rs1_data,
	input  word_t     idex_rs2_data,
	input  word_t     idex_imm,
	input  reg_addr_t idex_rs1,
	input  reg_addr_t idex_rs2,
	input  reg_addr_t idex_rd,
	input  alu_op_t   idex_alu_op,
	input  logic      idex_use_imm,
	input  logic      idex_link,
	input  logic      idex_branch,
	input  logic      idex_mem_read,
	input  logic      idex_mem_write,
	input  logic      idex_reg_write,
	input  logic      wb_enable,
	input  reg_addr_t wb_addr,
	input  word_t     wb_data,
	output word_t     exmem_result,
	output word_t     exmem_store_data,
	output word_t     exmem_branch_target,
	output reg_addr_t exmem_rd,
	output logic      exmem_zero,
	output logic      exmem_branch,
	output logic      exmem_mem_read,
	output logic      exmem_mem_write,
	output logic      exmem_reg_write
);

	word_t fwd_a;
	word_t fwd_b;
	word_t alu_b;
	word_t alu_out;

	// newest producer first; a load in EX/MEM only has its address there
	function automatic word_t forward(input reg_addr_t src, input word_t reg_value);
		if (src != '0 && exmem_reg_write && !exmem_mem_read && exmem_rd == src) begin
			return exmem_result;
		end else if (src != '0 && wb_enable && wb_addr == src) begin
			return wb_data;
		end
		return reg_value;
	endfunction

	always_comb begin
		fwd_a = forward(idex_rs1, idex_rs1_data);
		fwd_b = forward(idex_rs2, idex_rs2_data);
	end

	assign alu_b = idex_use_imm ? idex_imm : fwd_b;

	always_comb begin
		case (idex_alu_op)
			alu_sub: alu_out = fwd_a - alu_b;
			alu_and: alu_out = fwd_a & alu_b;
			alu_or:  alu_out = fwd_a | alu_b;
			alu_xor: alu_out = fwd_a ^ alu_b;
			alu_slt: alu_out = {{(XLEN-1){1'b0}}, $signed(fwd_a) < $signed(alu_b)};
			default: alu_out = fwd_a + alu_b;
		endcase
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exmem_branch <= 1'b0;
			exmem_mem_read <= 1'b0;
			exmem_mem_write <= 1'b0;
			exmem_reg_write <= 1'b0;
		end else if (!stall) begin
			exmem_branch <= !flush && idex_branch;
			exmem_mem_read <= !flush && idex_mem_read;
			exmem_mem_write <= !flush && idex_mem_write;
			exmem_reg_write <= !flush && idex_reg_write;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			// jal writes its return address
			exmem_result <= idex_link ? idex_pc + 32'd4 : alu_out;
			exmem_store_data <= fwd_b;
			exmem_branch_target <= idex_pc + idex_imm;
			exmem_rd <= idex_rd;
			exmem_zero <= (alu_out == '0);
		end
	end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import rv_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      stall,
	input  logic      flush,
	input  word_t     ifid_pc,
	input  word_t     ifid_instr,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	input  word_t     rs1_data,
	input  word_t     rs2_data,
	output logic      jump_taken,
	output word_t     jump_target,
	output reg_addr_t idex_rd,
	output word_t     idex_pc,
	output word_t     idex_rs1_data,
	output word_t     idex_rs2_data,
	output word_t     idex_imm,
	output reg_addr_t idex_rs1,
	output reg_addr_t idex_rs2,
	output alu_op_t   idex_alu_op,
	output logic      idex_use_imm,
	output logic      idex_link,
	output logic      idex_branch,
	output logic      idex_mem_read,
	output logic      idex_mem_write,
	output logic      idex_reg_write
);

	opcode_t   opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rd;
	word_t     imm_i;
	word_t     imm_s;
	word_t     imm_b;
	word_t     imm_j;
	word_t     imm;
	alu_op_t   alu_op;
	logic      use_imm;
	logic      branch;
	logic      mem_read;
	logic      mem_write;
	logic      reg_write;

	assign opcode = opcode_t'(ifid_instr[6:0]);
	assign rd = ifid_instr[11:7];
	assign funct3 = ifid_instr[14:12];
	assign rs1_addr = ifid_instr[19:15];
	assign rs2_addr = ifid_instr[24:20];
	assign funct7 = ifid_instr[31:25];

	assign imm_i = {{(XLEN-12){ifid_instr[31]}}, ifid_instr[31:20]};
	assign imm_s = {{(XLEN-12){ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
	assign imm_b = {{(XLEN-13){ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
		ifid_instr[30:25], ifid_instr[11:8], 1'b0};
	assign imm_j = {{(XLEN-21){ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
		ifid_instr[20], ifid_instr[30:21], 1'b0};

	always_comb begin
		imm = imm_i;
		alu_op = alu_add;
		use_imm = 1'b0;
		branch = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		jump_taken = 1'b0;
		case (opcode)
			op_reg: begin
				reg_write = 1'b1;
				case (funct3)
					3'b000: alu_op = funct7[5] ? alu_sub : alu_add;
					3'b010: alu_op = alu_slt;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					default: alu_op = alu_add;
				endcase
			end
			op_imm: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			op_load: begin
				use_imm = 1'b1;
				mem_read = 1'b1;
				reg_write = 1'b1;
			end
			op_store: begin
				imm = imm_s;
				use_imm = 1'b1;
				mem_write = 1'b1;
			end
			op_branch: begin
				// beq only, compared through a subtract
				imm = imm_b;
				alu_op = alu_sub;
				branch = (funct3 == 3'b000);
			end
			op_jal: begin
				imm = imm_j;
				reg_write = 1'b1;
				jump_taken = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign jump_target = ifid_pc + imm_j;

	// controls, cleared for a bubble
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			idex_alu_op <= alu_add;
			idex_use_imm <= 1'b0;
			idex_link <= 1'b0;
			idex_branch <= 1'b0;
			idex_mem_read <= 1'b0;
			idex_mem_write <= 1'b0;
			idex_reg_write <= 1'b0;
		end else if (!stall) begin
			idex_alu_op <= flush ? alu_add : alu_op;
			idex_use_imm <= !flush && use_imm;
			idex_link <= !flush && jump_taken;
			idex_branch <= !flush && branch;
			idex_mem_read <= !flush && mem_read;
			idex_mem_write <= !flush && mem_write;
			idex_reg_write <= !flush && reg_write;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			idex_pc <= ifid_pc;
			idex_rs1_data <= rs1_data;
			idex_rs2_data <= rs2_data;
			idex_imm <= imm;
			idex_rs1 <= rs1_addr;
			idex_rs2 <= rs2_addr;
			idex_rd <= rd;
		end
	end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file import rv_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t read_addr_a,
	input  reg_addr_t read_addr_b,
	output word_t     read_data_a,
	output word_t     read_data_b,
	input  logic      write_enable,
	input  reg_addr_t write_addr,
	input  word_t     write_data
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	// write-through so decode sees the value retiring this cycle
	always_comb begin
		if (read_addr_a == '0) begin
			read_data_a = '0;
		end else if (write_enable && write_addr == read_addr_a) begin
			read_data_a = write_data;
		end else begin
			read_data_a = regs[read_addr_a];
		end
		if (read_addr_b == '0) begin
			read_data_b = '0;
		end else if (write_enable && write_addr == read_addr_b) begin
			read_data_b = write_data;
		end else begin
			read_data_b = regs[read_addr_b];
		end
	end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import rv_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  stall,
	input  logic  flush,
	input  logic  jump_taken,
	input  word_t jump_target,
	input  logic  branch_taken,
	input  word_t branch_target,
	output word_t instr_addr,
	input  word_t instr_data,
	output word_t ifid_pc,
	output word_t ifid_instr
);

	word_t pc;
	word_t next_pc;

	// beq from memory is older than jal in decode, so it wins
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else if (jump_taken) begin
			next_pc = jump_target;
		end else begin
			next_pc = pc + 32'd4;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= RESET_PC;
			ifid_instr <= BUBBLE_INSTR;
		end else if (!stall) begin
			pc <= next_pc;
			// squash the instruction fetched alongside a redirect
			ifid_instr <= flush ? BUBBLE_INSTR : instr_data;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			ifid_pc <= pc;
		end
	end

	assign instr_addr = pc;

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// first fetch address out of reset
	localparam word_t RESET_PC = 32'h0000_0000;

	// addi x0, x0, 0
	localparam word_t BUBBLE_INSTR = 32'h0000_0013;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

endpackage

`default_nettype wire
